// ==== include/rename_params.svh ====
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// architectural register count seen by software
`define ARCH_REGS 32

// physical registers backing the rename pool
`define PHYS_REGS 64

// width of one register value
`define REG_WIDTH 32

`endif

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

    `include "rename_params.svh"

    // index into the architectural map
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_idx_t;

    // index into the physical register file
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_idx_t;

    // one register value
    typedef logic [`REG_WIDTH-1:0] reg_val_t;

endpackage

// ==== rtl/arch_map_table.sv ====
`timescale 1ns/1ps

`include "rename_params.svh"

module arch_map_table (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  uop_update,
    input  rename_pkg::arch_idx_t arch_rd1,
    input  rename_pkg::arch_idx_t arch_rd2,
    input  rename_pkg::arch_idx_t arch_wr,
    input  rename_pkg::phys_idx_t new_phys,

    input  logic                  rob_update,
    input  rename_pkg::arch_idx_t arch_rob_update,
    input  rename_pkg::phys_idx_t arch_rob_nonspec_phys,

    input  logic                  rollback,

    output rename_pkg::phys_idx_t arch_rd1_phys,
    output rename_pkg::phys_idx_t arch_rd2_phys,
    output rename_pkg::phys_idx_t arch_wr_oldphys
);

    import rename_pkg::*;

    phys_idx_t spec_map   [`ARCH_REGS];
    phys_idx_t commit_map [`ARCH_REGS];
    phys_idx_t spec_nxt   [`ARCH_REGS];
    phys_idx_t commit_nxt [`ARCH_REGS];

    // lookups see the map as it was before this edge
    assign arch_rd1_phys   = spec_map[arch_rd1];
    assign arch_rd2_phys   = spec_map[arch_rd2];
    assign arch_wr_oldphys = spec_map[arch_wr];

    always_comb begin
        commit_nxt = commit_map;
        if (rob_update) begin
            commit_nxt[arch_rob_update] = arch_rob_nonspec_phys;
        end

        // rollback sees the commit of the same cycle, and drops the rename
        spec_nxt = spec_map;
        if (rollback) begin
            spec_nxt = commit_nxt;
        end else if (uop_update) begin
            spec_nxt[arch_wr] = new_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // identity mapping out of reset
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i]   <= phys_idx_t'(i);
                commit_map[i] <= phys_idx_t'(i);
            end
        end else begin
            spec_map   <= spec_nxt;
            commit_map <= commit_nxt;
        end
    end

endmodule

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps

`include "rename_params.svh"

module free_list (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  alloc,

    input  logic                  rob_update,
    input  rename_pkg::phys_idx_t phys_rob_nonspec,
    input  rename_pkg::phys_idx_t phys_rob_free,

    input  logic                  rollback,

    output rename_pkg::phys_idx_t next_free,
    output logic                  none_free
);

    import rename_pkg::*;

    logic [`PHYS_REGS-1:0] free_vec;
    logic [`PHYS_REGS-1:0] commit_vec;
    logic [`PHYS_REGS-1:0] free_nxt;
    logic [`PHYS_REGS-1:0] commit_nxt;

    // lowest free index wins
    always_comb begin
        next_free = '0;
        for (int i = `PHYS_REGS - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                next_free = phys_idx_t'(i);
            end
        end
    end

    assign none_free = ~|free_vec;

    always_comb begin
        free_nxt   = free_vec;
        commit_nxt = commit_vec;
        if (alloc && !rollback) begin
            free_nxt[next_free] = 1'b0;
        end
        if (rob_update) begin
            commit_nxt[phys_rob_nonspec] = 1'b1;
            commit_nxt[phys_rob_free]    = 1'b0;
            free_nxt[phys_rob_free]      = 1'b1;
        end
        // anything not committed goes back to the pool
        if (rollback) begin
            free_nxt = ~commit_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                free_vec[i]   <= (i >= `ARCH_REGS);
                commit_vec[i] <= (i < `ARCH_REGS);
            end
        end else begin
            free_vec   <= free_nxt;
            commit_vec <= commit_nxt;
        end
    end

endmodule

// ==== rtl/phys_reg_file.sv ====
`timescale 1ns/1ps

`include "rename_params.svh"

module phys_reg_file (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  alloc,
    input  rename_pkg::phys_idx_t alloc_phys,
    input  rename_pkg::phys_idx_t rd1,
    input  rename_pkg::phys_idx_t rd2,

    input  logic                  ring_update,
    input  rename_pkg::phys_idx_t phys_ring,
    input  rename_pkg::reg_val_t  phys_ring_val,

    input  logic                  rollback,

    output rename_pkg::reg_val_t  rd1_val,
    output rename_pkg::reg_val_t  rd2_val,
    output logic                  rd1_rdy,
    output logic                  rd2_rdy
);

    import rename_pkg::*;

    reg_val_t              vals [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] rdy_vec;
    logic                  take;

    // rollback in the same cycle drops the rename
    assign take = alloc && !rollback;

    // read ports capture only on a rename
    always_ff @(posedge clk) begin
        if (reset) begin
            rd1_val <= '0;
            rd2_val <= '0;
            rd1_rdy <= 1'b0;
            rd2_rdy <= 1'b0;
        end else if (take) begin
            rd1_val <= vals[rd1];
            rd2_val <= vals[rd2];
            rd1_rdy <= rdy_vec[rd1];
            rd2_rdy <= rdy_vec[rd2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                vals[i]    <= '0;
                rdy_vec[i] <= (i < `ARCH_REGS);
            end
        end else begin
            if (take) begin
                rdy_vec[alloc_phys] <= 1'b0;
            end
            // write-back ring
            if (ring_update) begin
                vals[phys_ring]    <= phys_ring_val;
                rdy_vec[phys_ring] <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/regfile_top.sv ====
`timescale 1ns/1ps

module regfile_top (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  uop_update,
    input  rename_pkg::arch_idx_t arch_rd1,
    input  rename_pkg::arch_idx_t arch_rd2,
    input  rename_pkg::arch_idx_t arch_wr,

    input  logic                  ring_update,
    input  rename_pkg::phys_idx_t phys_ring,
    input  rename_pkg::reg_val_t  phys_ring_val,

    input  logic                  rob_update,
    input  rename_pkg::arch_idx_t arch_rob_update,
    input  rename_pkg::phys_idx_t arch_rob_nonspec_phys,
    input  rename_pkg::phys_idx_t phys_rob_free,

    input  logic                  rollback,

    output logic                  phys_rd1_rdy,
    output logic                  phys_rd2_rdy,
    output rename_pkg::phys_idx_t phys_rd1,
    output rename_pkg::phys_idx_t phys_rd2,
    output rename_pkg::reg_val_t  phys_rd1_val,
    output rename_pkg::reg_val_t  phys_rd2_val,
    output rename_pkg::phys_idx_t phys_wr,
    output rename_pkg::phys_idx_t oldphys_wr,
    output logic                  none_free
);

    import rename_pkg::*;

    logic      rename_ok;
    phys_idx_t next_free;
    phys_idx_t arch_rd1_phys;
    phys_idx_t arch_rd2_phys;
    phys_idx_t arch_wr_oldphys;

    // a rename is dropped when the pool is empty or a rollback hits
    assign rename_ok = uop_update && !none_free && !rollback;

    always_ff @(posedge clk) begin
        if (reset) begin
            phys_rd1   <= '0;
            phys_rd2   <= '0;
            phys_wr    <= '0;
            oldphys_wr <= '0;
        end else if (rename_ok) begin
            phys_rd1   <= arch_rd1_phys;
            phys_rd2   <= arch_rd2_phys;
            phys_wr    <= next_free;
            oldphys_wr <= arch_wr_oldphys;
        end
    end

    arch_map_table u_map (
        .clk                   (clk),
        .reset                 (reset),
        .uop_update            (rename_ok),
        .arch_rd1              (arch_rd1),
        .arch_rd2              (arch_rd2),
        .arch_wr               (arch_wr),
        .new_phys              (next_free),
        .rob_update            (rob_update),
        .arch_rob_update       (arch_rob_update),
        .arch_rob_nonspec_phys (arch_rob_nonspec_phys),
        .rollback              (rollback),
        .arch_rd1_phys         (arch_rd1_phys),
        .arch_rd2_phys         (arch_rd2_phys),
        .arch_wr_oldphys       (arch_wr_oldphys)
    );

    free_list u_free (
        .clk              (clk),
        .reset            (reset),
        .alloc            (rename_ok),
        .rob_update       (rob_update),
        .phys_rob_nonspec (arch_rob_nonspec_phys),
        .phys_rob_free    (phys_rob_free),
        .rollback         (rollback),
        .next_free        (next_free),
        .none_free        (none_free)
    );

    phys_reg_file u_prf (
        .clk           (clk),
        .reset         (reset),
        .alloc         (rename_ok),
        .alloc_phys    (next_free),
        .rd1           (arch_rd1_phys),
        .rd2           (arch_rd2_phys),
        .ring_update   (ring_update),
        .phys_ring     (phys_ring),
        .phys_ring_val (phys_ring_val),
        .rollback      (rollback),
        .rd1_val       (phys_rd1_val),
        .rd2_val       (phys_rd2_val),
        .rd1_rdy       (phys_rd1_rdy),
        .rd2_rdy       (phys_rd2_rdy)
    );

endmodule

// ==== dv/regfile_tb.sv ====
`timescale 1ns/1ps

`include "rename_params.svh"

module regfile_tb;

    import rename_pkg::*;

    localparam int OP_IDLE     = 0;
    localparam int OP_RENAME   = 1;
    localparam int OP_RING     = 2;
    localparam int OP_COMMIT   = 3;
    localparam int OP_ROLLBACK = 4;

    // a rename takes sources from a and b and the destination from c
    // a ring write uses a as the physical register
    // a commit maps arch reg a to physical reg b and releases c
    typedef struct packed {
        int test;
        int kind;
        int a;
        int b;
        int c;
        int exp_wr;
    } op_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      uop_update;
    arch_idx_t arch_rd1;
    arch_idx_t arch_rd2;
    arch_idx_t arch_wr;
    logic      ring_update;
    phys_idx_t phys_ring;
    reg_val_t  phys_ring_val;
    logic      rob_update;
    arch_idx_t arch_rob_update;
    phys_idx_t arch_rob_nonspec_phys;
    phys_idx_t phys_rob_free;
    logic      rollback;
    logic      phys_rd1_rdy;
    logic      phys_rd2_rdy;
    phys_idx_t phys_rd1;
    phys_idx_t phys_rd2;
    reg_val_t  phys_rd1_val;
    reg_val_t  phys_rd2_val;
    phys_idx_t phys_wr;
    phys_idx_t oldphys_wr;
    logic      none_free;

    op_t         ops[$];
    bit          table_ready = 1'b0;
    logic [31:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          test_errs = 0;
    int          tests_run = 0;

    // reference model state
    int       spec_m [`ARCH_REGS];
    int       com_m  [`ARCH_REGS];
    bit       free_m [`PHYS_REGS];
    bit       com_v  [`PHYS_REGS];
    bit       rdy_m  [`PHYS_REGS];
    reg_val_t val_m  [`PHYS_REGS];
    int       exp_rd1;
    int       exp_rd2;
    int       exp_wr;
    int       exp_old;
    reg_val_t exp_v1;
    reg_val_t exp_v2;
    bit       exp_r1;
    bit       exp_r2;

    regfile_top u_dut (
        .clk                   (clk),
        .reset                 (reset),
        .uop_update            (uop_update),
        .arch_rd1              (arch_rd1),
        .arch_rd2              (arch_rd2),
        .arch_wr               (arch_wr),
        .ring_update           (ring_update),
        .phys_ring             (phys_ring),
        .phys_ring_val         (phys_ring_val),
        .rob_update            (rob_update),
        .arch_rob_update       (arch_rob_update),
        .arch_rob_nonspec_phys (arch_rob_nonspec_phys),
        .phys_rob_free         (phys_rob_free),
        .rollback              (rollback),
        .phys_rd1_rdy          (phys_rd1_rdy),
        .phys_rd2_rdy          (phys_rd2_rdy),
        .phys_rd1              (phys_rd1),
        .phys_rd2              (phys_rd2),
        .phys_rd1_val          (phys_rd1_val),
        .phys_rd2_val          (phys_rd2_val),
        .phys_wr               (phys_wr),
        .oldphys_wr            (oldphys_wr),
        .none_free             (none_free)
    );

    always #10 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int lowest_free();
        for (int k = 0; k < `PHYS_REGS; k++) begin
            if (free_m[k]) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset state";
            2: return "renaming chain";
            3: return "ring write-back";
            4: return "commit and free";
            5: return "rollback";
            default: return "exhaustion";
        endcase
    endfunction

    task automatic add_op(input int test, input int kind, input int a, input int b,
                          input int c, input int want_wr);
        op_t op;
        op = '{test, kind, a, b, c, want_wr};
        ops.push_back(op);
    endtask

    task automatic build_table();
        add_op(1, OP_RENAME, 3, 7, 3, 32);
        add_op(2, OP_RENAME, 3, 4, 5, 33);
        add_op(2, OP_RENAME, 5, 5, 5, 34);
        add_op(2, OP_RENAME, 1, 2, 6, 35);
        add_op(3, OP_RING, 32, 0, 0, -1);
        add_op(3, OP_RING, 34, 0, 0, -1);
        add_op(3, OP_IDLE, 0, 0, 0, -1);
        add_op(3, OP_RENAME, 3, 5, 8, 36);
        add_op(4, OP_COMMIT, 3, 32, 3, -1);
        add_op(4, OP_RENAME, 9, 9, 9, 3);
        add_op(4, OP_COMMIT, 5, 33, 5, -1);
        add_op(4, OP_COMMIT, 5, 34, 33, -1);
        add_op(4, OP_RENAME, 10, 10, 10, 5);
        // rename offered with the rollback is dropped
        add_op(5, OP_ROLLBACK, 12, 13, 14, 5);
        add_op(5, OP_RENAME, 3, 9, 11, 3);
        add_op(6, OP_ROLLBACK, 0, 0, 0, 3);
        for (int k = 0; k < 32; k++) begin
            add_op(6, OP_RENAME, k, (k + 1) % 32, k, (k == 0) ? 3 : ((k == 31) ? 63 : -1));
        end
        add_op(6, OP_RENAME, 20, 21, 22, 63);
        add_op(6, OP_IDLE, 0, 0, 0, 63);
        // one freed register shows the dropped rename left the map alone
        add_op(6, OP_COMMIT, 0, 3, 0, 63);
        add_op(6, OP_RENAME, 22, 0, 21, 0);
    endtask

    task automatic model_reset();
        for (int k = 0; k < `ARCH_REGS; k++) begin
            spec_m[k] = k;
            com_m[k]  = k;
        end
        for (int k = 0; k < `PHYS_REGS; k++) begin
            free_m[k] = (k >= `ARCH_REGS);
            com_v[k]  = (k < `ARCH_REGS);
            rdy_m[k]  = (k < `ARCH_REGS);
            val_m[k]  = '0;
        end
        exp_rd1 = 0;
        exp_rd2 = 0;
        exp_wr  = 0;
        exp_old = 0;
        exp_v1  = '0;
        exp_v2  = '0;
        exp_r1  = 1'b0;
        exp_r2  = 1'b0;
    endtask

    task automatic clear_strobes();
        uop_update  = 1'b0;
        ring_update = 1'b0;
        rob_update  = 1'b0;
        rollback    = 1'b0;
    endtask

    task automatic apply_op(input op_t op);
        int nf;
        clear_strobes();
        case (op.kind)
            OP_RENAME, OP_ROLLBACK: begin
                uop_update = 1'b1;
                arch_rd1   = arch_idx_t'(op.a);
                arch_rd2   = arch_idx_t'(op.b);
                arch_wr    = arch_idx_t'(op.c);
                nf = lowest_free();
                if (op.kind == OP_ROLLBACK) begin
                    rollback = 1'b1;
                    for (int k = 0; k < `ARCH_REGS; k++) begin
                        spec_m[k] = com_m[k];
                    end
                    for (int k = 0; k < `PHYS_REGS; k++) begin
                        free_m[k] = !com_v[k];
                    end
                end else if (nf >= 0) begin
                    // sources and old destination before the new mapping
                    exp_rd1 = spec_m[op.a];
                    exp_rd2 = spec_m[op.b];
                    exp_old = spec_m[op.c];
                    exp_v1  = val_m[exp_rd1];
                    exp_v2  = val_m[exp_rd2];
                    exp_r1  = rdy_m[exp_rd1];
                    exp_r2  = rdy_m[exp_rd2];
                    exp_wr  = nf;
                    spec_m[op.c] = nf;
                    free_m[nf]   = 1'b0;
                    rdy_m[nf]    = 1'b0;
                end
            end
            OP_RING: begin
                ring_update   = 1'b1;
                phys_ring     = phys_idx_t'(op.a);
                phys_ring_val = take_bits(`REG_WIDTH);
                val_m[op.a]   = phys_ring_val;
                rdy_m[op.a]   = 1'b1;
            end
            OP_COMMIT: begin
                rob_update            = 1'b1;
                arch_rob_update       = arch_idx_t'(op.a);
                arch_rob_nonspec_phys = phys_idx_t'(op.b);
                phys_rob_free         = phys_idx_t'(op.c);
                com_m[op.a]  = op.b;
                com_v[op.b]  = 1'b1;
                com_v[op.c]  = 1'b0;
                free_m[op.c] = 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_field(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, want);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_outputs(input int want_wr);
        check_field("phys_rd1", 32'(phys_rd1), exp_rd1);
        check_field("phys_rd2", 32'(phys_rd2), exp_rd2);
        check_field("phys_wr", 32'(phys_wr), exp_wr);
        check_field("oldphys_wr", 32'(oldphys_wr), exp_old);
        check_field("phys_rd1_val", phys_rd1_val, exp_v1);
        check_field("phys_rd2_val", phys_rd2_val, exp_v2);
        check_field("phys_rd1_rdy", 32'(phys_rd1_rdy), 32'(exp_r1));
        check_field("phys_rd2_rdy", 32'(phys_rd2_rdy), 32'(exp_r2));
        check_field("none_free", 32'(none_free), 32'(lowest_free() < 0));
        // fixed value from the table
        if (want_wr >= 0) begin
            check_field("phys_wr vs table", 32'(phys_wr), want_wr);
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d %s: %0d errors", id, test_name(id), test_errs);
        tests_run++;
        test_errs = 0;
    endtask

    initial begin
        reset                 = 1'b1;
        uop_update            = 1'b0;
        arch_rd1              = '0;
        arch_rd2              = '0;
        arch_wr               = '0;
        ring_update           = 1'b0;
        phys_ring             = '0;
        phys_ring_val         = '0;
        rob_update            = 1'b0;
        arch_rob_update       = '0;
        arch_rob_nonspec_phys = '0;
        phys_rob_free         = '0;
        rollback              = 1'b0;
        lfsr                  = 32'd61;
        build_table();
        model_reset();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i <= ops.size(); i++) begin
            @(posedge clk);
            #1;
            check_outputs((i > 0) ? ops[i-1].exp_wr : -1);
            if (i > 0 && (i == ops.size() || ops[i].test != ops[i-1].test)) begin
                report_test(ops[i-1].test);
            end
            if (i < ops.size()) begin
                apply_op(ops[i]);
            end else begin
                clear_strobes();
            end
        end
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((ops.size() + 8) * 20 + 100);
        $display("timeout: the stimulus table did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
rtl/rename_pkg.sv
rtl/arch_map_table.sv
rtl/free_list.sv
rtl/phys_reg_file.sv
rtl/regfile_top.sv
dv/regfile_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := regfile_tb
FILELIST  := files.f
OBJDIR    := obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
